// File: verilog/winRatePkg.sv
// shared sizes, widths and enums for the nine-seat win-rate engine
// design files refer to these by scoped names, e.g. winRatePkg::Idle
package winRatePkg;

    // ============================================================
    // table and deck
    // ============================================================
    localparam int NumPlayers   = 9;
    localparam int HoleCards    = 2 * NumPlayers;
    localparam int PubCards     = 3;
    localparam int DeckSize     = 52;
    localparam int RanksPerSuit = 13;
    // the two is rank 2, the ace is rank 14
    localparam int MinRank      = 2;
    localparam int RankWidth    = 4;
    localparam int SuitWidth    = 2;

    localparam int UnseenCards  = DeckSize - HoleCards - PubCards;
    localparam int PairCount    = UnseenCards * (UnseenCards - 1) / 2;

    // ============================================================
    // share arithmetic
    // ============================================================
    // one pair's share splits evenly among 1 to 9 winners
    localparam int ShareUnit    = 2520;
    localparam int RateDivisor  = PairCount * ShareUnit / 100;
    localparam int RateWidth    = 7;
    localparam int AccWidth     = 21;

    // category on top, then five kicker ranks, strongest first
    localparam int ScoreWidth   = 3 + 5 * RankWidth;

    typedef enum logic [2:0] {
        Idle, Load, Scan, Drain, Report
    } ctrlState_e;

    typedef enum logic [2:0] {
        HighCard, OnePair, TwoPair, Trips, FullHouse, Quads
    } handCategory_e;

endpackage

// File: verilog/winRateCtrl.sv
// run sequencer for the win-rate engine
// Idle waits for a strobe, Load compacts the deck, Scan walks the pairs,
// Drain lets the pipeline empty and Report publishes the rates
module winRateCtrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inValid,
    input  logic                   loadDone,
    input  logic                   pairLast,
    output winRatePkg::ctrlState_e state
);
    winRatePkg::ctrlState_e nextState;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= winRatePkg::Idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            winRatePkg::Idle: begin
                // strobes outside Idle are dropped here
                if (inValid) begin
                    nextState = winRatePkg::Load;
                end
            end
            winRatePkg::Load: begin
                if (loadDone) begin
                    nextState = winRatePkg::Scan;
                end
            end
            winRatePkg::Scan: begin
                if (pairLast) begin
                    nextState = winRatePkg::Drain;
                end
            end
            // one cycle for the last pair to leave the judge
            winRatePkg::Drain:  nextState = winRatePkg::Report;
            winRatePkg::Report: nextState = winRatePkg::Idle;
            default:            nextState = winRatePkg::Idle;
        endcase
    end

endmodule

// File: verilog/deckScanner.sv
// captures the deal, lists the 31 unseen ranks in deck order during Load,
// then presents every unseen pair once during Scan, one pair per clock
// a card's deck index is suit * 13 + rank - 2
module deckScanner (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  winRatePkg::ctrlState_e                               state,
    input  logic                                                 inValid,
    input  logic [winRatePkg::HoleCards*winRatePkg::RankWidth-1:0] inHoleNum,
    input  logic [winRatePkg::HoleCards*winRatePkg::SuitWidth-1:0] inHoleSuit,
    input  logic [winRatePkg::PubCards*winRatePkg::RankWidth-1:0]  inPubNum,
    input  logic [winRatePkg::PubCards*winRatePkg::SuitWidth-1:0]  inPubSuit,
    output logic [winRatePkg::HoleCards*winRatePkg::RankWidth-1:0] holeRanks,
    output logic [winRatePkg::PubCards*winRatePkg::RankWidth-1:0]  pubRanks,
    output logic [winRatePkg::RankWidth-1:0]                     turnRank,
    output logic [winRatePkg::RankWidth-1:0]                     riverRank,
    output logic                                                 pairValid,
    output logic                                                 loadDone,
    output logic                                                 pairLast
);
    localparam int Rw       = winRatePkg::RankWidth;
    localparam int Sw       = winRatePkg::SuitWidth;
    localparam int IdxWidth = $clog2(winRatePkg::DeckSize);
    localparam int PtrWidth = $clog2(winRatePkg::UnseenCards);

    logic [winRatePkg::HoleCards*Sw-1:0] holeSuit;
    logic [winRatePkg::PubCards*Sw-1:0]  pubSuit;
    logic [winRatePkg::DeckSize-1:0]     taken;
    logic [Rw-1:0]                       unseenQ [winRatePkg::UnseenCards];
    logic [IdxWidth-1:0]                 deckIdx;
    logic [PtrWidth-1:0]                 wrPtr;
    logic [PtrWidth-1:0]                 firstPtr;
    logic [PtrWidth-1:0]                 secondPtr;

    always_ff @(posedge clk) begin
        if (inValid && state == winRatePkg::Idle) begin
            holeRanks <= inHoleNum;
            holeSuit  <= inHoleSuit;
            pubRanks  <= inPubNum;
            pubSuit   <= inPubSuit;
        end
    end

    // mark the 21 dealt cards
    always_comb begin
        int idx;
        taken = '0;
        for (int h = 0; h < winRatePkg::HoleCards; h++) begin
            idx = int'(holeSuit[h*Sw +: Sw]) * winRatePkg::RanksPerSuit
                + int'(holeRanks[h*Rw +: Rw]) - winRatePkg::MinRank;
            if (idx >= 0 && idx < winRatePkg::DeckSize)
                taken[idx] = 1'b1;
        end
        for (int p = 0; p < winRatePkg::PubCards; p++) begin
            idx = int'(pubSuit[p*Sw +: Sw]) * winRatePkg::RanksPerSuit
                + int'(pubRanks[p*Rw +: Rw]) - winRatePkg::MinRank;
            if (idx >= 0 && idx < winRatePkg::DeckSize)
                taken[idx] = 1'b1;
        end
    end

    // ============================================================
    // Load: one deck index per cycle
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            deckIdx <= '0;
            wrPtr   <= '0;
        end else if (state == winRatePkg::Load) begin
            deckIdx <= deckIdx + 1'b1;
            if (!taken[deckIdx])
                wrPtr <= wrPtr + 1'b1;
        end else begin
            deckIdx <= '0;
            wrPtr   <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == winRatePkg::Load && !taken[deckIdx])
            unseenQ[wrPtr] <= Rw'(deckIdx % winRatePkg::RanksPerSuit + winRatePkg::MinRank);
    end

    assign loadDone = (state == winRatePkg::Load) &&
                      (deckIdx == IdxWidth'(winRatePkg::DeckSize - 1));

    // ============================================================
    // Scan: second pointer runs above the first
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            firstPtr  <= '0;
            secondPtr <= PtrWidth'(1);
        end else if (state == winRatePkg::Scan) begin
            if (secondPtr == PtrWidth'(winRatePkg::UnseenCards - 1)) begin
                firstPtr  <= firstPtr + 1'b1;
                secondPtr <= firstPtr + PtrWidth'(2);
            end else begin
                secondPtr <= secondPtr + 1'b1;
            end
        end else begin
            firstPtr  <= '0;
            secondPtr <= PtrWidth'(1);
        end
    end

    assign turnRank  = unseenQ[firstPtr];
    assign riverRank = unseenQ[secondPtr];
    assign pairValid = (state == winRatePkg::Scan);
    // last pair is the top two queue entries
    assign pairLast  = pairValid && (firstPtr == PtrWidth'(winRatePkg::UnseenCards - 2));

endmodule

// File: verilog/handEvaluator.sv
// combinational score of a seven-card hand from rank counts alone
// straights and flushes are not ranked; a larger score is a stronger hand
// score = {category, five kicker ranks}, unused kickers are zero
module handEvaluator (
    input  logic [7*winRatePkg::RankWidth-1:0] cardRanks,
    output logic [winRatePkg::ScoreWidth-1:0]  score
);
    localparam int Rw      = winRatePkg::RankWidth;
    localparam int TopRank = winRatePkg::MinRank + winRatePkg::RanksPerSuit - 1;

    logic [2:0]                  counts [2**Rw];
    logic [Rw-1:0]               quadR;
    logic [Rw-1:0]               tripHi;
    logic [Rw-1:0]               tripLo;
    logic [Rw-1:0]               pairHi;
    logic [Rw-1:0]               pairMid;
    logic [Rw-1:0]               pairLo;
    logic [Rw-1:0]               single [5];
    logic [2:0]                  nSingle;
    logic [Rw-1:0]               kick [5];
    winRatePkg::handCategory_e   category;

    function automatic logic [Rw-1:0] maxRank(input logic [Rw-1:0] a, input logic [Rw-1:0] b);
        return (a > b) ? a : b;
    endfunction

    // group ranks by multiplicity
    always_comb begin
        counts  = '{default: '0};
        quadR   = '0;
        tripHi  = '0;
        tripLo  = '0;
        pairHi  = '0;
        pairMid = '0;
        pairLo  = '0;
        single  = '{default: '0};
        nSingle = '0;
        for (int c = 0; c < 7; c++)
            counts[cardRanks[c*Rw +: Rw]] = counts[cardRanks[c*Rw +: Rw]] + 3'd1;
        // ace down, so every list comes out sorted
        for (int r = TopRank; r >= winRatePkg::MinRank; r--) begin
            case (counts[r])
                3'd4: quadR = Rw'(r);
                3'd3: begin
                    if (tripHi == '0)
                        tripHi = Rw'(r);
                    else
                        tripLo = Rw'(r);
                end
                3'd2: begin
                    if (pairHi == '0)
                        pairHi = Rw'(r);
                    else if (pairMid == '0)
                        pairMid = Rw'(r);
                    else if (pairLo == '0)
                        pairLo = Rw'(r);
                end
                3'd1: begin
                    if (nSingle < 3'd5) begin
                        single[nSingle] = Rw'(r);
                        nSingle = nSingle + 3'd1;
                    end
                end
                default: ;
            endcase
        end
    end

    // ============================================================
    // category and kickers
    // ============================================================
    always_comb begin
        kick = '{default: '0};
        if (quadR != '0) begin
            category = winRatePkg::Quads;
            kick[0]  = quadR;
            kick[1]  = maxRank(maxRank(tripHi, pairHi), single[0]);
        end else if (tripHi != '0 && (tripLo != '0 || pairHi != '0)) begin
            // a second trip counts as the pair
            category = winRatePkg::FullHouse;
            kick[0]  = tripHi;
            kick[1]  = maxRank(tripLo, pairHi);
        end else if (tripHi != '0) begin
            category = winRatePkg::Trips;
            kick[0]  = tripHi;
            kick[1]  = single[0];
            kick[2]  = single[1];
        end else if (pairMid != '0) begin
            category = winRatePkg::TwoPair;
            kick[0]  = pairHi;
            kick[1]  = pairMid;
            kick[2]  = maxRank(pairLo, single[0]);
        end else if (pairHi != '0) begin
            category = winRatePkg::OnePair;
            kick[0]  = pairHi;
            kick[1]  = single[0];
            kick[2]  = single[1];
            kick[3]  = single[2];
        end else begin
            category = winRatePkg::HighCard;
            kick     = single;
        end
    end

    assign score = {category, kick[0], kick[1], kick[2], kick[3], kick[4]};

endmodule

// File: verilog/showdownJudge.sv
// scores every seat against the board plus the current turn and river,
// marks all seats that share the best score and counts them
// results are registered, one cycle after the pair
module showdownJudge (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic [winRatePkg::HoleCards*winRatePkg::RankWidth-1:0] holeRanks,
    input  logic [winRatePkg::PubCards*winRatePkg::RankWidth-1:0]  pubRanks,
    input  logic [winRatePkg::RankWidth-1:0]                     turnRank,
    input  logic [winRatePkg::RankWidth-1:0]                     riverRank,
    input  logic                                                 pairValid,
    output logic [winRatePkg::NumPlayers-1:0]                    winMask,
    output logic [3:0]                                           winCount,
    output logic                                                 winValid
);
    localparam int Rw = winRatePkg::RankWidth;

    logic [winRatePkg::ScoreWidth-1:0] seatScore [winRatePkg::NumPlayers];
    logic [winRatePkg::ScoreWidth-1:0] bestScore;
    logic [winRatePkg::NumPlayers-1:0] mask;
    logic [3:0]                        count;

    for (genvar k = 0; k < winRatePkg::NumPlayers; k++) begin : gSeat
        handEvaluator evalI (
            .cardRanks({riverRank, turnRank, pubRanks, holeRanks[2*k*Rw +: 2*Rw]}),
            .score    (seatScore[k])
        );
    end

    always_comb begin
        bestScore = '0;
        mask      = '0;
        count     = '0;
        for (int k = 0; k < winRatePkg::NumPlayers; k++) begin
            if (seatScore[k] > bestScore)
                bestScore = seatScore[k];
        end
        // ties split the pot
        for (int k = 0; k < winRatePkg::NumPlayers; k++) begin
            mask[k] = (seatScore[k] == bestScore);
            count   = count + 4'(mask[k]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            winValid <= 1'b0;
        else
            winValid <= pairValid;
    end

    always_ff @(posedge clk) begin
        winMask  <= mask;
        winCount <= count;
    end

endmodule

// File: verilog/shareAccumulator.sv
// sums each seat's split shares over all pairs, then in Report turns
// the totals into whole percentages, rounded down
// outWinRate is nonzero only in the cycle outValid is high
module shareAccumulator (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  winRatePkg::ctrlState_e                                state,
    input  logic [winRatePkg::NumPlayers-1:0]                     winMask,
    input  logic [3:0]                                            winCount,
    input  logic                                                  winValid,
    output logic                                                  outValid,
    output logic [winRatePkg::NumPlayers*winRatePkg::RateWidth-1:0] outWinRate
);
    localparam int Aw = winRatePkg::AccWidth;
    localparam int Rt = winRatePkg::RateWidth;

    logic [Aw-1:0] total [winRatePkg::NumPlayers];
    logic [Aw-1:0] share;

    // 2520 divides evenly for any winner count
    assign share = (winCount == 4'd0) ? '0 : Aw'(winRatePkg::ShareUnit / int'(winCount));

    always_ff @(posedge clk) begin
        if (state == winRatePkg::Idle) begin
            total <= '{default: '0};
        end else if (winValid) begin
            for (int k = 0; k < winRatePkg::NumPlayers; k++) begin
                if (winMask[k])
                    total[k] <= total[k] + share;
            end
        end
    end

    // ============================================================
    // report
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outValid   <= 1'b0;
            outWinRate <= '0;
        end else if (state == winRatePkg::Report) begin
            outValid <= 1'b1;
            for (int k = 0; k < winRatePkg::NumPlayers; k++)
                outWinRate[k*Rt +: Rt] <= Rt'(total[k] / winRatePkg::RateDivisor);
        end else begin
            outValid   <= 1'b0;
            outWinRate <= '0;
        end
    end

endmodule

// File: verilog/winRateTop.sv
// top level of the flop win-rate engine
// one inValid strobe loads the deal, outValid pulses 520 cycles later
// with each seat's rate as a whole percentage in outWinRate
module winRateTop (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 inValid,
    input  logic [winRatePkg::HoleCards*winRatePkg::RankWidth-1:0] inHoleNum,
    input  logic [winRatePkg::HoleCards*winRatePkg::SuitWidth-1:0] inHoleSuit,
    input  logic [winRatePkg::PubCards*winRatePkg::RankWidth-1:0]  inPubNum,
    input  logic [winRatePkg::PubCards*winRatePkg::SuitWidth-1:0]  inPubSuit,
    output logic                                                 outValid,
    output logic [winRatePkg::NumPlayers*winRatePkg::RateWidth-1:0] outWinRate
);
    winRatePkg::ctrlState_e                                    state;
    logic                                                      loadDone;
    logic                                                      pairLast;
    logic                                                      pairValid;
    logic [winRatePkg::HoleCards*winRatePkg::RankWidth-1:0]    holeRanks;
    logic [winRatePkg::PubCards*winRatePkg::RankWidth-1:0]     pubRanks;
    logic [winRatePkg::RankWidth-1:0]                          turnRank;
    logic [winRatePkg::RankWidth-1:0]                          riverRank;
    logic [winRatePkg::NumPlayers-1:0]                         winMask;
    logic [3:0]                                                winCount;
    logic                                                      winValid;

    winRateCtrl ctrlI (.clk, .rst_n, .inValid, .loadDone, .pairLast, .state);

    deckScanner scanI (
        .clk, .rst_n, .state, .inValid, .inHoleNum, .inHoleSuit, .inPubNum, .inPubSuit,
        .holeRanks, .pubRanks, .turnRank, .riverRank, .pairValid, .loadDone, .pairLast
    );

    showdownJudge judgeI (
        .clk, .rst_n, .holeRanks, .pubRanks, .turnRank, .riverRank, .pairValid,
        .winMask, .winCount, .winValid
    );

    shareAccumulator accI (
        .clk, .rst_n, .state, .winMask, .winCount, .winValid, .outValid, .outWinRate
    );

endmodule

// File: testbench/winRate_asserts.sv
// protocol checks on the top level of the win-rate engine
// bound into winRateTop, watches the strobe, the ctrl state and the report
module winRateAsserts (
    input logic                                                  clk,
    input logic                                                  rst_n,
    input logic                                                  inValid,
    input winRatePkg::ctrlState_e                                state,
    input logic                                                  outValid,
    input logic [winRatePkg::NumPlayers*winRatePkg::RateWidth-1:0] outWinRate
);
    localparam int Latency = 520;

    // report is a single-cycle pulse
    reportPulse: assert property (@(posedge clk) disable iff (!rst_n)
        outValid |=> !outValid)
        else $error("outValid stayed high for more than one cycle");

    ratesOnlyWithValid: assert property (@(posedge clk) disable iff (!rst_n)
        !outValid |-> (outWinRate == '0))
        else $error("outWinRate nonzero while outValid is low");

    // outValid loads at edge 519 and is first sampled high at edge 520
    reportLatency: assert property (@(posedge clk) disable iff (!rst_n)
        (inValid && state == winRatePkg::Idle) |-> ##Latency outValid)
        else $error("outValid did not follow the accepted strobe by 520 cycles");

endmodule

bind winRateTop winRateAsserts assertsI (
    .clk, .rst_n, .inValid, .state, .outValid, .outWinRate
);

// File: include/tbHandModel.svh
// reference model for the win-rate testbench
// scores a seven-card hand by rank groups and kickers, then walks every
// unseen turn and river pair to get each seat's rounded-down percentage
`ifndef TB_HAND_MODEL_SVH
`define TB_HAND_MODEL_SVH

// highest rank holding at least minCount cards, skipping one rank
function automatic int topRankOf(input int cnt[15], input int minCount, input int skip);
    for (int r = 14; r >= 2; r--) begin
        if (cnt[r] >= minCount && r != skip)
            return r;
    end
    return 0;
endfunction

// category in the top bits, then the defining ranks, then the kickers
function automatic int handScore(input int ranks[7]);
    int cnt[15];
    int keys[5];
    int nKeys;
    int slots;
    int cat;
    int quadR;
    int tripR;
    int pairA;
    int pairB;
    cnt  = '{default: 0};
    keys = '{default: 0};
    for (int c = 0; c < 7; c++)
        cnt[ranks[c]]++;
    quadR = topRankOf(cnt, 4, 0);
    tripR = topRankOf(cnt, 3, 0);
    pairA = topRankOf(cnt, 2, tripR);
    pairB = topRankOf(cnt, 2, pairA);
    // slots is the number of ranks that a five-card hand compares on
    if (quadR != 0) begin
        cat = 5; keys[0] = quadR; nKeys = 1; slots = 2;
    end else if (tripR != 0 && pairA != 0) begin
        cat = 4; keys[0] = tripR; keys[1] = pairA; nKeys = 2; slots = 2;
    end else if (tripR != 0) begin
        cat = 3; keys[0] = tripR; nKeys = 1; slots = 3;
    end else if (pairB != 0) begin
        cat = 2; keys[0] = pairA; keys[1] = pairB; nKeys = 2; slots = 3;
    end else if (pairA != 0) begin
        cat = 1; keys[0] = pairA; nKeys = 1; slots = 4;
    end else begin
        cat = 0; nKeys = 0; slots = 5;
    end
    // kickers are the best leftover cards
    for (int r = 14; r >= 2; r--) begin
        if (cnt[r] > 0 && r != keys[0] && r != keys[1] && nKeys < slots) begin
            keys[nKeys] = r;
            nKeys++;
        end
    end
    return (cat << 20) | (keys[0] << 16) | (keys[1] << 12) | (keys[2] << 8)
         | (keys[3] << 4) | keys[4];
endfunction

// seats own entries 2k and 2k+1, the flop sits in entries 18 to 20
function automatic void computeRates(input int ranks[21], input int suits[21],
                                     output int rates[9]);
    bit  taken[52];
    int  unseen[$];
    int  total[9];
    int  hand[7];
    int  scores[9];
    int  best;
    int  winners;
    taken = '{default: 1'b0};
    total = '{default: 0};
    for (int i = 0; i < 21; i++)
        taken[suits[i] * 13 + ranks[i] - 2] = 1'b1;
    for (int idx = 0; idx < 52; idx++) begin
        if (!taken[idx])
            unseen.push_back(idx % 13 + 2);
    end
    for (int i = 0; i < unseen.size(); i++) begin
        for (int j = i + 1; j < unseen.size(); j++) begin
            best    = 0;
            winners = 0;
            for (int k = 0; k < 9; k++) begin
                hand = '{ranks[2*k], ranks[2*k+1], ranks[18], ranks[19], ranks[20],
                         unseen[i], unseen[j]};
                scores[k] = handScore(hand);
                if (scores[k] > best)
                    best = scores[k];
            end
            for (int k = 0; k < 9; k++)
                winners += (scores[k] == best) ? 1 : 0;
            for (int k = 0; k < 9; k++) begin
                if (scores[k] == best)
                    total[k] += winRatePkg::ShareUnit / winners;
            end
        end
    end
    for (int k = 0; k < 9; k++)
        rates[k] = total[k] / winRatePkg::RateDivisor;
endfunction

`endif

// File: testbench/tbWinRate.sv
// directed testbench for winRateTop
// deals distinct cards from an LFSR, strobes the deal in, waits for the
// report and compares every seat with the reference model
module tbWinRate;

    localparam int Period        = 8;
    localparam int ResetCycles   = 16;
    localparam int Seed          = 87862;
    localparam int ReportLatency = 520;
    // five reports of 520 cycles, plus reset and quiet windows
    localparam int RunCycles     = 600;
    localparam int TimeoutCycles = 5 * RunCycles;
    localparam int StrobeOffset  = 100;
    localparam int QuietCycles   = 200;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        inValid;
    logic [71:0] inHoleNum;
    logic [35:0] inHoleSuit;
    logic [11:0] inPubNum;
    logic [5:0]  inPubSuit;
    logic        outValid;
    logic [62:0] outWinRate;

    logic [16:0] lfsr;
    int          cycleCount;
    int          dealRank [21];
    int          dealSuit [21];
    bit          used [52];

    `include "tbHandModel.svh"

    winRateTop dut_i (
        .clk, .rst_n, .inValid, .inHoleNum, .inHoleSuit, .inPubNum, .inPubSuit,
        .outValid, .outWinRate
    );

    always #(Period / 2) clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Done: errors found");
            $fatal(1, "timeout: no end of test after %0d cycles", cycleCount);
        end
    end

    // ============================================================
    // dealing
    // ============================================================
    // x^17 + x^14 + 1
    function automatic logic lfsrBit();
        logic fb;
        fb   = lfsr[16] ^ lfsr[13];
        lfsr = {lfsr[15:0], fb};
        return fb;
    endfunction

    function automatic int randBits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
            v = (v << 1) | int'(lfsrBit());
        return v;
    endfunction

    task automatic drawCard(output int rank, output int suit);
        int idx;
        do begin
            idx = randBits(6);
        end while (idx >= 52 || used[idx]);
        used[idx] = 1'b1;
        rank = idx % 13 + 2;
        suit = idx / 13;
    endtask

    task automatic placeCard(input int pos, input int rank, input int suit);
        used[suit * 13 + rank - 2] = 1'b1;
        dealRank[pos] = rank;
        dealSuit[pos] = suit;
    endtask

    task automatic dealRandom();
        used = '{default: 1'b0};
        for (int i = 0; i < 21; i++)
            drawCard(dealRank[i], dealSuit[i]);
    endtask

    // ============================================================
    // DUT handshake and checks
    // ============================================================
    task automatic pulseStrobe();
        logic [71:0] hn;
        logic [35:0] hs;
        logic [11:0] pn;
        logic [5:0]  ps;
        for (int i = 0; i < 18; i++) begin
            hn[i*4 +: 4] = 4'(dealRank[i]);
            hs[i*2 +: 2] = 2'(dealSuit[i]);
        end
        for (int p = 0; p < 3; p++) begin
            pn[p*4 +: 4] = 4'(dealRank[18 + p]);
            ps[p*2 +: 2] = 2'(dealSuit[18 + p]);
        end
        @(posedge clk);
        inHoleNum  <= hn;
        inHoleSuit <= hs;
        inPubNum   <= pn;
        inPubSuit  <= ps;
        inValid    <= 1'b1;
        @(posedge clk);
        inValid <= 1'b0;
    endtask

    task automatic checkValue(input string name, input longint expected, input longint actual);
        assert (expected == actual)
        else begin
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
            $display("Done: errors found");
            $fatal(1, "check %s did not match", name);
        end
    endtask

    // spent counts cycles already gone since the accepted strobe edge
    task automatic waitReport(input string name, input int spent, output int rates[9]);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!outValid);
        // the pulse seen at negedge n is sampled high at edge n
        checkValue({name, " latency"}, ReportLatency, spent + n);
        for (int k = 0; k < 9; k++)
            rates[k] = int'(outWinRate[k*7 +: 7]);
    endtask

    task automatic compareRates(input string name, input int actual[9]);
        int expected[9];
        int sum;
        sum = 0;
        for (int k = 0; k < 9; k++)
            sum += actual[k];
        // each seat rounds down, the exact shares add to 100
        assert (sum >= 91 && sum <= 100)
        else begin
            $display("FAILED %s rate sum: expected 91 to 100, actual %0d", name, sum);
            $display("Done: errors found");
            $fatal(1, "rate sum out of range");
        end
        computeRates(dealRank, dealSuit, expected);
        for (int k = 0; k < 9; k++)
            checkValue($sformatf("%s seat %0d", name, k), expected[k], actual[k]);
    endtask

    task automatic playAndCompare(input string name);
        int actual[9];
        pulseStrobe();
        waitReport(name, 0, actual);
        compareRates(name, actual);
    endtask

    // ============================================================
    // directed tests
    // ============================================================
    task automatic quietAfterReset();
        repeat (20) begin
            @(negedge clk);
            checkValue("reset outValid", 0, outValid);
            checkValue("reset outWinRate", 0, outWinRate);
        end
    endtask

    task automatic randomDeal();
        dealRandom();
        playAndCompare("random deal");
    endtask

    // seat 0 makes four aces, nobody can match it
    task automatic quadAcesDeal();
        int actual[9];
        used = '{default: 1'b0};
        placeCard(0, 14, 0);
        placeCard(1, 14, 1);
        placeCard(18, 14, 2);
        placeCard(19, 14, 3);
        for (int i = 2; i < 18; i++)
            drawCard(dealRank[i], dealSuit[i]);
        drawCard(dealRank[20], dealSuit[20]);
        pulseStrobe();
        waitReport("quad aces", 0, actual);
        for (int k = 0; k < 9; k++)
            checkValue($sformatf("quad aces seat %0d", k), (k == 0) ? 100 : 0, actual[k]);
    endtask

    task automatic backToBackDeals();
        dealRandom();
        playAndCompare("back to back first");
        dealRandom();
        playAndCompare("back to back second");
    endtask

    task automatic strobeDuringRun();
        int actual[9];
        int savedRank[21];
        int savedSuit[21];
        dealRandom();
        savedRank = dealRank;
        savedSuit = dealSuit;
        pulseStrobe();
        repeat (StrobeOffset) @(negedge clk);
        // a different deal strobed while the engine is busy
        dealRandom();
        pulseStrobe();
        waitReport("strobe during run", StrobeOffset + 1, actual);
        dealRank = savedRank;
        dealSuit = savedSuit;
        compareRates("strobe during run", actual);
        repeat (QuietCycles) begin
            @(negedge clk);
            checkValue("strobe during run second report", 0, outValid);
        end
    endtask

    initial begin
        rst_n      <= 1'b0;
        inValid    <= 1'b0;
        inHoleNum  <= '0;
        inHoleSuit <= '0;
        inPubNum   <= '0;
        inPubSuit  <= '0;
        lfsr = 17'(Seed);
        repeat (ResetCycles) @(posedge clk);
        rst_n <= 1'b1;
        quietAfterReset();
        randomDeal();
        quadAcesDeal();
        backToBackDeals();
        strobeDuringRun();
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: all.f
+incdir+include
verilog/winRatePkg.sv
verilog/winRateCtrl.sv
verilog/deckScanner.sv
verilog/handEvaluator.sv
verilog/showdownJudge.sv
verilog/shareAccumulator.sv
verilog/winRateTop.sv
testbench/winRate_asserts.sv
testbench/tbWinRate.sv

// File: run.sh
#!/usr/bin/env bash
# builds the win-rate testbench with Verilator and runs it
# exit status is nonzero if the build or the simulation fails

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tbWinRate -f all.f -o simWinRate; then
    echo "build failed"
    exit 1
fi

./obj_dir/simWinRate
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished cleanly"
exit 0
